//--- Bender.yml
package:
  name: videogen_subsystem

sources:
  - video_pkg.sv
  - clut_pkg.sv
  - clut_ram.sv
  - clut_arbiter.sv
  - pixel_lookup.sv
  - palette_host_port.sv
  - videogen_subsystem.sv
  - target: test
    files:
      - videogen_assertions.sv
      - tb_videogen_subsystem.sv

//--- clut_arbiter.sv
`timescale 1ns/1ps

module clut_arbiter #(
	parameter int INDEX_W = video_pkg::INDEX_W_DEF,
	parameter int BANK_W  = video_pkg::BANK_W_DEF,
	parameter int COLOR_W = video_pkg::COLOR_W_DEF
) (
	input  logic                                        clk_6md,
	input  logic                                        rst_n,
	input  logic                                        pix_req,
	input  logic [INDEX_W+BANK_W-1:0]                   pix_addr,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  pix_rdata,
	input  logic                                        host_req,
	input  logic                                        host_we,
	input  logic [INDEX_W+BANK_W-1:0]                   host_addr,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  host_wdata,
	output logic                                        host_gnt,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  host_rdata,
	output logic                                        ram_en,
	output logic                                        ram_we,
	output logic [INDEX_W+BANK_W-1:0]                   ram_addr,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  ram_wdata,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  ram_rdata
);

	import clut_pkg::*;

	// Owner of the read issued on the previous edge
	clut_owner_e owner_q;

	////////////////////////////////
	// Grant and request mux
	////////////////////////////////

	// Pixel path wins outright, host fills the gaps
	assign host_gnt = ~pix_req;

	always_comb begin
		ram_en    = pix_req | host_req;
		// Host may only write while the pixel path is idle
		ram_we    = ~pix_req & host_req & host_we;
		ram_addr  = pix_req ? pix_addr : host_addr;
		ram_wdata = host_wdata;
	end

	////////////////////////////////
	// Read data steering
	////////////////////////////////

	// Track who gets the RAM output next cycle
	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			owner_q <= OWNER_NONE;
		end else if (pix_req) begin
			owner_q <= OWNER_PIXEL;
		end else if (host_req && !host_we) begin
			owner_q <= OWNER_HOST;
		end else begin
			owner_q <= OWNER_NONE;
		end
	end

	// The other side sees zero
	assign pix_rdata  = (owner_q == OWNER_PIXEL) ? ram_rdata : '0;
	assign host_rdata = (owner_q == OWNER_HOST) ? ram_rdata : '0;

endmodule

//--- clut_pkg.sv
package clut_pkg;

	////////////////////////////////
	// Host side encodings
	////////////////////////////////

	// Palette access opcode
	typedef enum logic [0:0] {
		CLUT_WRITE = 1'b0,
		CLUT_READ  = 1'b1
	} clut_op_e;

	// Requester whose read is in flight
	typedef enum logic [1:0] {
		OWNER_NONE  = 2'd0,
		OWNER_PIXEL = 2'd1,
		OWNER_HOST  = 2'd2
	} clut_owner_e;

	// Host port command FSM
	typedef enum logic [1:0] {
		HOST_IDLE  = 2'd0,
		HOST_ISSUE = 2'd1,
		HOST_RSP   = 2'd2
	} host_state_e;

endpackage

//--- clut_ram.sv
`timescale 1ns/1ps

module clut_ram #(
	parameter int ADDR_W = 9,
	parameter int DATA_W = 12
) (
	input  logic              clk_6md,
	input  logic              ram_en,
	input  logic              ram_we,
	input  logic [ADDR_W-1:0] ram_addr,
	input  logic [DATA_W-1:0] ram_wdata,
	output logic [DATA_W-1:0] ram_rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	// Palette storage, one word per bank/index pair
	logic [DATA_W-1:0] mem [DEPTH];

	////////////////////////////////
	// Single port access
	////////////////////////////////

	// Write or read on an enabled cycle
	// Read data lands one edge after the request
	always_ff @(posedge clk_6md) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_addr] <= ram_wdata;
			end else begin
				ram_rdata <= mem[ram_addr];
			end
		end
	end

endmodule

//--- palette_host_port.sv
`timescale 1ns/1ps

module palette_host_port #(
	parameter int INDEX_W = video_pkg::INDEX_W_DEF,
	parameter int BANK_W  = video_pkg::BANK_W_DEF,
	parameter int COLOR_W = video_pkg::COLOR_W_DEF
) (
	input  logic                                        clk_6md,
	input  logic                                        rst_n,
	input  logic                                        cmd_valid,
	output logic                                        cmd_ready,
	input  clut_pkg::clut_op_e                          cmd_op,
	input  logic [INDEX_W+BANK_W-1:0]                   cmd_addr,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  cmd_wdata,
	output logic                                        rsp_valid,
	input  logic                                        rsp_ready,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  rsp_data,
	output logic                                        host_req,
	output logic                                        host_we,
	output logic [INDEX_W+BANK_W-1:0]                   host_addr,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  host_wdata,
	input  logic                                        host_gnt,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  host_rdata
);

	import clut_pkg::*;
	import video_pkg::*;

	localparam int DATA_W = NUM_CHANNELS * COLOR_W;

	host_state_e state_q;

	// One entry command buffer
	clut_op_e                  op_q;
	logic [INDEX_W+BANK_W-1:0] addr_q;
	logic [DATA_W-1:0]         wdata_q;

	// High on the first response cycle while RAM data is live
	logic                      rsp_capture_q;
	logic [DATA_W-1:0]         rsp_hold_q;

	////////////////////////////////
	// Command FSM
	////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			state_q       <= HOST_IDLE;
			rsp_capture_q <= 1'b0;
		end else begin
			rsp_capture_q <= 1'b0;
			case (state_q)
				HOST_IDLE: begin
					if (cmd_valid) state_q <= HOST_ISSUE;
				end
				HOST_ISSUE: begin
					// Wait out active video
					if (host_gnt) begin
						if (op_q == CLUT_READ) begin
							state_q       <= HOST_RSP;
							rsp_capture_q <= 1'b1;
						end else begin
							state_q <= HOST_IDLE;
						end
					end
				end
				HOST_RSP: begin
					if (rsp_ready) state_q <= HOST_IDLE;
				end
				default: state_q <= HOST_IDLE;
			endcase
		end
	end

	// Buffer loads on an accepted command
	always_ff @(posedge clk_6md) begin
		if (cmd_valid && cmd_ready) begin
			op_q    <= cmd_op;
			addr_q  <= cmd_addr;
			wdata_q <= cmd_wdata;
		end
		if (rsp_capture_q) rsp_hold_q <= host_rdata;
	end

	////////////////////////////////
	// Outputs
	////////////////////////////////

	assign cmd_ready  = (state_q == HOST_IDLE);
	assign host_req   = (state_q == HOST_ISSUE);
	assign host_we    = (op_q == CLUT_WRITE);
	assign host_addr  = addr_q;
	assign host_wdata = wdata_q;

	// Live RAM data first, then the held copy
	assign rsp_valid  = (state_q == HOST_RSP);
	assign rsp_data   = rsp_capture_q ? host_rdata : rsp_hold_q;

endmodule

//--- pixel_lookup.sv
`timescale 1ns/1ps

module pixel_lookup #(
	parameter int INDEX_W = video_pkg::INDEX_W_DEF,
	parameter int BANK_W  = video_pkg::BANK_W_DEF,
	parameter int COLOR_W = video_pkg::COLOR_W_DEF
) (
	input  logic                                        clk_6md,
	input  logic                                        rst_n,
	input  logic [INDEX_W-1:0]                          index,
	input  logic [BANK_W-1:0]                           bank,
	input  logic                                        enable,
	input  logic                                        sync,
	output logic                                        pix_req,
	output logic [INDEX_W+BANK_W-1:0]                   pix_addr,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  pix_rdata,
	output logic [COLOR_W-1:0]                          red,
	output logic [COLOR_W-1:0]                          green,
	output logic [COLOR_W-1:0]                          blue,
	output logic                                        sync_out
);

	import video_pkg::*;

	// Stage one latches
	logic [INDEX_W-1:0] index_q;
	logic [BANK_W-1:0]  bank_q;
	logic               enable_q;
	logic               sync_q;

	// Delay line to meet the RAM output
	logic               enable_qq;
	logic               sync_qq;

	////////////////////////////////
	// Stage one  index latch
	////////////////////////////////

	always_ff @(posedge clk_6md) begin
		index_q <= index;
		bank_q  <= bank;
	end

	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			enable_q  <= 1'b0;
			sync_q    <= 1'b0;
			enable_qq <= 1'b0;
			sync_qq   <= 1'b0;
		end else begin
			enable_q  <= enable;
			sync_q    <= sync;
			enable_qq <= enable_q;
			sync_qq   <= sync_q;
		end
	end

	// Bank picks the upper half of the CLUT
	assign pix_addr = {bank_q, index_q};
	// Only look up while video is on
	assign pix_req  = enable_q;

	////////////////////////////////
	// Stage two  colour registers
	////////////////////////////////

	// Black during blanking
	always_ff @(posedge clk_6md) begin
		if (!rst_n || !enable_qq) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else begin
			red   <= pix_rdata[CH_RED*COLOR_W +: COLOR_W];
			green <= pix_rdata[CH_GREEN*COLOR_W +: COLOR_W];
			blue  <= pix_rdata[CH_BLUE*COLOR_W +: COLOR_W];
		end
	end

	// Sync rides alongside the colour
	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			sync_out <= 1'b0;
		end else begin
			sync_out <= sync_qq;
		end
	end

endmodule

//--- tb_videogen_subsystem.sv
`timescale 1ns/1ps

module tb_videogen_subsystem;

	import video_pkg::*;
	import clut_pkg::*;

	localparam int INDEX_W    = INDEX_W_DEF;
	localparam int BANK_W     = BANK_W_DEF;
	localparam int COLOR_W    = COLOR_W_DEF;
	localparam int ADDR_W     = INDEX_W + BANK_W;
	localparam int DATA_W     = NUM_CHANNELS * COLOR_W;
	localparam int N_ENTRIES  = 1 << ADDR_W;
	localparam int N_READS    = 64;
	localparam int N_STREAM   = 256;
	localparam int N_MIXED    = 256;
	localparam int N_PENDING  = 20;
	localparam int N_HOLD     = 6;
	localparam int WAIT_LIMIT = 64;
	localparam int CLK_PERIOD = 4;
	// Writes take two cycles, reads about four
	localparam int MAX_CYCLES = 2 * N_ENTRIES + 4 * N_READS + N_STREAM + N_MIXED
		+ N_PENDING + N_HOLD + 100;

	logic               clk_6md;
	logic               rst_n;
	logic [INDEX_W-1:0] index;
	logic [BANK_W-1:0]  bank;
	logic               enable;
	logic               sync;
	logic [COLOR_W-1:0] red;
	logic [COLOR_W-1:0] green;
	logic [COLOR_W-1:0] blue;
	logic               sync_out;
	logic               cmd_valid;
	logic               cmd_ready;
	clut_op_e           cmd_op;
	logic [ADDR_W-1:0]  cmd_addr;
	logic [DATA_W-1:0]  cmd_wdata;
	logic               rsp_valid;
	logic               rsp_ready;
	logic [DATA_W-1:0]  rsp_data;

	integer seed = 32'h665259f7;
	int errors = 0;

	// Palette as the host wrote it
	logic [DATA_W-1:0] mirror [N_ENTRIES];
	// Sync on top, colour word below
	logic [DATA_W:0] exp_q [$];

	videogen_subsystem u_dut (.*);

	initial begin
		clk_6md = 1'b0;
		forever #(CLK_PERIOD / 2) clk_6md = ~clk_6md;
	end

	////////////////////////////////
	// Helpers
	////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic fail_now(input string msg);
		errors++;
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped");
	endtask

	// Expected colour word, black while blanked
	function automatic logic [DATA_W-1:0] ref_colour(input logic [BANK_W-1:0] b,
			input logic [INDEX_W-1:0] i, input logic en);
		if (!en) return '0;
		return mirror[{b, i}];
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic next_cycle();
		@(posedge clk_6md);
		#1;
	endtask

	task automatic drive_pixel(input logic en);
		logic [31:0] r;
		r = rand_word();
		index  = r[INDEX_W-1:0];
		bank   = r[INDEX_W +: BANK_W];
		sync   = r[31];
		enable = en;
	endtask

	// Returns one cycle after the accepting edge
	task automatic send_cmd(input clut_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		int n;
		n = 0;
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_addr  = addr;
		cmd_wdata = wdata;
		while (!cmd_ready) begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT) fail_now("Host port never accepted the command");
		end
		next_cycle();
		cmd_valid = 1'b0;
		if (op == CLUT_WRITE) mirror[addr] = wdata;
	endtask

	task automatic expect_rsp(input logic [DATA_W-1:0] expected);
		int n;
		n = 0;
		while (!rsp_valid) begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT) fail_now("No read response came back from the host port");
		end
		check_value("rsp_data", expected, rsp_data);
		if (rsp_ready) next_cycle();
	endtask

	////////////////////////////////
	// Pixel output checker
	////////////////////////////////

	// Inputs seen at a falling edge show up three falling edges later
	initial begin
		logic [DATA_W:0] e;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk_6md);
			if (exp_q.size() == 3) begin
				e = exp_q.pop_front();
				check_value("red", e[0 +: COLOR_W], red);
				check_value("green", e[COLOR_W +: COLOR_W], green);
				check_value("blue", e[2 * COLOR_W +: COLOR_W], blue);
				check_value("sync_out", e[DATA_W], sync_out);
			end
			exp_q.push_back({sync, ref_colour(bank, index, enable)});
		end
	end

	initial begin
		#(MAX_CYCLES * CLK_PERIOD + 100);
		$display("Timeout: the run went past its planned number of clock cycles");
		$display("SIMULATION FAILED");
		$fatal(1, "Watchdog expired");
	end

	////////////////////////////////
	// Stimulus
	////////////////////////////////

	initial begin
		logic [31:0]       r;
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] addr2;
		rst_n     = 1'b0;
		index     = '0;
		bank      = '0;
		enable    = 1'b0;
		sync      = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = CLUT_WRITE;
		cmd_addr  = '0;
		cmd_wdata = '0;
		rsp_ready = 1'b1;
		repeat (2) @(posedge clk_6md);
		#1;
		rst_n = 1'b1;

		// Reset state
		check_value("red", 0, red);
		check_value("green", 0, green);
		check_value("blue", 0, blue);
		check_value("sync_out", 0, sync_out);
		check_value("rsp_valid", 0, rsp_valid);
		check_value("cmd_ready", 1, cmd_ready);

		// Fill the whole palette during blanking, then sample it back
		for (int a = 0; a < N_ENTRIES; a++) begin
			r = rand_word();
			addr = a[ADDR_W-1:0];
			send_cmd(CLUT_WRITE, addr, r[DATA_W-1:0]);
		end
		repeat (N_READS) begin
			r = rand_word();
			addr = r[ADDR_W-1:0];
			send_cmd(CLUT_READ, addr, '0);
			expect_rsp(mirror[addr]);
		end

		// Active video, one pixel per cycle
		repeat (N_STREAM) begin
			drive_pixel(1'b1);
			next_cycle();
		end

		// Blanking cycles scattered through the stream
		repeat (N_MIXED) begin
			r = rand_word();
			drive_pixel(r[1:0] != 2'b00);
			next_cycle();
		end

		// Host read stalls behind active video
		drive_pixel(1'b1);
		r = rand_word();
		addr = r[ADDR_W-1:0];
		send_cmd(CLUT_READ, addr, '0);
		repeat (N_PENDING) begin
			drive_pixel(1'b1);
			check_value("cmd_ready", 0, cmd_ready);
			check_value("rsp_valid", 0, rsp_valid);
			next_cycle();
		end
		drive_pixel(1'b0);
		expect_rsp(mirror[addr]);

		// Back-pressure on the response
		rsp_ready = 1'b0;
		r = rand_word();
		addr = r[ADDR_W-1:0];
		addr2 = r[31 -: ADDR_W];
		send_cmd(CLUT_READ, addr, '0);
		expect_rsp(mirror[addr]);
		cmd_valid = 1'b1;
		cmd_op    = CLUT_READ;
		cmd_addr  = addr2;
		repeat (N_HOLD) begin
			next_cycle();
			check_value("rsp_valid", 1, rsp_valid);
			check_value("rsp_data", mirror[addr], rsp_data);
			check_value("cmd_ready", 0, cmd_ready);
		end
		rsp_ready = 1'b1;
		next_cycle();
		check_value("rsp_valid", 0, rsp_valid);
		check_value("cmd_ready", 1, cmd_ready);
		send_cmd(CLUT_READ, addr2, '0);
		expect_rsp(mirror[addr2]);

		// Let the pixel pipeline drain
		repeat (4) next_cycle();
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- video_pkg.sv
package video_pkg;

	////////////////////////////////
	// Default pixel widths
	////////////////////////////////

	// Pixel index from the tile and sprite mixer
	parameter int INDEX_W_DEF = 8;

	// Palette bank select
	parameter int BANK_W_DEF = 1;

	// Bits per colour channel
	parameter int COLOR_W_DEF = 4;

	////////////////////////////////
	// Colour word layout
	////////////////////////////////

	// Red, green and blue packed in one CLUT word
	parameter int NUM_CHANNELS = 3;

	// Channel slots counted from the low end
	parameter int CH_RED   = 0;
	parameter int CH_GREEN = 1;
	parameter int CH_BLUE  = 2;

endpackage

//--- videogen_assertions.sv
`timescale 1ns/1ps

module videogen_assertions #(
	parameter int DATA_W = 12
) (
	input  logic                  clk_6md,
	input  logic                  rst_n,
	input  logic                  pix_req,
	input  logic                  host_req,
	input  logic                  host_gnt,
	input  logic                  ram_en,
	input  clut_pkg::clut_owner_e owner_q,
	input  logic                  cmd_ready,
	input  logic                  rsp_valid,
	input  logic                  rsp_ready,
	input  logic [DATA_W-1:0]     rsp_data
);

	import clut_pkg::*;

	////////////////////////////////
	// Arbitration
	////////////////////////////////

	// Pixel path and host never both own the RAM
	a_exclusive_grant: assert property (@(posedge clk_6md) disable iff (!rst_n)
		!(host_gnt && pix_req))
		else $error("host_gnt high in the same cycle as pix_req");

	// RAM enable always comes from a live request
	a_no_stray_enable: assert property (@(posedge clk_6md) disable iff (!rst_n)
		!(ram_en && owner_q == OWNER_NONE && !pix_req && !host_req))
		else $error("ram_en high with no owner and no request");

	////////////////////////////////
	// Host handshake
	////////////////////////////////

	// No new command while a response waits
	a_ready_blocked: assert property (@(posedge clk_6md) disable iff (!rst_n)
		rsp_valid |-> !cmd_ready)
		else $error("cmd_ready high while rsp_valid is high");

	// Held response stays put under back-pressure
	a_rsp_stable: assert property (@(posedge clk_6md) disable iff (!rst_n)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
		else $error("rsp_data changed or rsp_valid dropped before rsp_ready");

endmodule

// Arbiter instance, handshake inputs idle
bind clut_arbiter videogen_assertions #(
	.DATA_W (video_pkg::NUM_CHANNELS * COLOR_W)
) u_arbiter_checks (
	.clk_6md   (clk_6md),
	.rst_n     (rst_n),
	.pix_req   (pix_req),
	.host_req  (host_req),
	.host_gnt  (host_gnt),
	.ram_en    (ram_en),
	.owner_q   (owner_q),
	.cmd_ready (1'b0),
	.rsp_valid (1'b0),
	.rsp_ready (1'b1),
	.rsp_data  ('0)
);

// Host port instance, RAM side inputs idle
bind palette_host_port videogen_assertions #(
	.DATA_W (video_pkg::NUM_CHANNELS * COLOR_W)
) u_host_checks (
	.clk_6md   (clk_6md),
	.rst_n     (rst_n),
	.pix_req   (1'b0),
	.host_req  (host_req),
	.host_gnt  (host_gnt),
	.ram_en    (1'b0),
	.owner_q   (clut_pkg::OWNER_NONE),
	.cmd_ready (cmd_ready),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_data  (rsp_data)
);

//--- videogen_subsystem.f
video_pkg.sv
clut_pkg.sv
clut_ram.sv
clut_arbiter.sv
pixel_lookup.sv
palette_host_port.sv
videogen_subsystem.sv
videogen_assertions.sv
tb_videogen_subsystem.sv

//--- videogen_subsystem.sv
`timescale 1ns/1ps

module videogen_subsystem #(
	parameter int INDEX_W = video_pkg::INDEX_W_DEF,
	parameter int BANK_W  = video_pkg::BANK_W_DEF,
	parameter int COLOR_W = video_pkg::COLOR_W_DEF
) (
	input  logic                                        clk_6md,
	input  logic                                        rst_n,
	input  logic [INDEX_W-1:0]                          index,
	input  logic [BANK_W-1:0]                           bank,
	input  logic                                        enable,
	input  logic                                        sync,
	output logic [COLOR_W-1:0]                          red,
	output logic [COLOR_W-1:0]                          green,
	output logic [COLOR_W-1:0]                          blue,
	output logic                                        sync_out,
	input  logic                                        cmd_valid,
	output logic                                        cmd_ready,
	input  clut_pkg::clut_op_e                          cmd_op,
	input  logic [INDEX_W+BANK_W-1:0]                   cmd_addr,
	input  logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  cmd_wdata,
	output logic                                        rsp_valid,
	input  logic                                        rsp_ready,
	output logic [video_pkg::NUM_CHANNELS*COLOR_W-1:0]  rsp_data
);

	import video_pkg::*;

	localparam int ADDR_W = INDEX_W + BANK_W;
	localparam int DATA_W = NUM_CHANNELS * COLOR_W;

	////////////////////////////////
	// Internal buses
	////////////////////////////////

	// Pixel path to arbiter
	logic              pix_req;
	logic [ADDR_W-1:0] pix_addr;
	logic [DATA_W-1:0] pix_rdata;

	// Host port to arbiter
	logic              host_req;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic              host_gnt;
	logic [DATA_W-1:0] host_rdata;

	// Arbiter to palette RAM
	logic              ram_en;
	logic              ram_we;
	logic [ADDR_W-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic [DATA_W-1:0] ram_rdata;

	pixel_lookup #(
		.INDEX_W (INDEX_W),
		.BANK_W  (BANK_W),
		.COLOR_W (COLOR_W)
	) u_pixel_lookup (
		.clk_6md   (clk_6md),
		.rst_n     (rst_n),
		.index     (index),
		.bank      (bank),
		.enable    (enable),
		.sync      (sync),
		.pix_req   (pix_req),
		.pix_addr  (pix_addr),
		.pix_rdata (pix_rdata),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.sync_out  (sync_out)
	);

	palette_host_port #(
		.INDEX_W (INDEX_W),
		.BANK_W  (BANK_W),
		.COLOR_W (COLOR_W)
	) u_host_port (
		.clk_6md    (clk_6md),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_data   (rsp_data),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata)
	);

	// Pixel lookups always win the RAM
	clut_arbiter #(
		.INDEX_W (INDEX_W),
		.BANK_W  (BANK_W),
		.COLOR_W (COLOR_W)
	) u_arbiter (
		.clk_6md    (clk_6md),
		.rst_n      (rst_n),
		.pix_req    (pix_req),
		.pix_addr   (pix_addr),
		.pix_rdata  (pix_rdata),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata),
		.ram_en     (ram_en),
		.ram_we     (ram_we),
		.ram_addr   (ram_addr),
		.ram_wdata  (ram_wdata),
		.ram_rdata  (ram_rdata)
	);

	clut_ram #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) u_clut_ram (
		.clk_6md   (clk_6md),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

endmodule
